/* design/fm_config.svh */
`ifndef FM_CONFIG_SVH
`define FM_CONFIG_SVH

// Width of one window's edge count
`define FM_COUNT_W 32

// Measured clocks, sample clock and reference clock
`define FM_NUM_CH 2

// ps_clk cycles per measurement window, 6.4 us at 100 ns
`define FM_GATE_CYCLES 64

// Flops per clock crossing
`define FM_SYNC_STAGES 3

`endif

/* design/fm_pkg.sv */
`default_nettype none

`include "fm_config.svh"

package fm_pkg;

    // Edge count of one measurement window
    typedef logic [`FM_COUNT_W-1:0] count_t;

    // Gate timer position, holds 0 to FM_GATE_CYCLES
    typedef logic [$clog2(`FM_GATE_CYCLES + 1)-1:0] gate_cnt_t;

    // One channel's result as seen in ps_clk
    typedef struct packed {
        logic   valid;  // One-cycle strobe per window
        count_t count;  // Held until the next load
    } freq_result_t;

endpackage

`default_nettype wire

/* design/gate_timer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fm_config.svh"

module gate_timer (
    input  logic ps_clk,
    input  logic rst_n_i,
    output logic gate_o
);
    import fm_pkg::*;

    gate_cnt_t gate_cnt;
    logic      wrap;

    // Last cycle of the window
    assign wrap = (gate_cnt == gate_cnt_t'(`FM_GATE_CYCLES - 1));

    always_ff @(posedge ps_clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            gate_cnt <= '0;
            gate_o   <= 1'b0;
        end else begin
            if (wrap) begin
                gate_cnt <= '0;
            end else begin
                gate_cnt <= gate_cnt + 1'b1;
            end

            // Pulse follows the zero count by one cycle
            gate_o <= (gate_cnt == '0);
        end
    end

endmodule

`default_nettype wire

/* design/flag_sync.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fm_config.svh"

module flag_sync #(
    parameter int STAGES = `FM_SYNC_STAGES
) (
    input  logic src_clk_i,
    input  logic dst_clk_i,
    input  logic rst_n_i,
    input  logic flag_i,
    output logic flag_o
);
    logic              toggle;  // Source domain, flips once per pulse
    logic [STAGES-1:0] sync;    // Destination domain chain, bit 0 is the first flop

    always_ff @(posedge src_clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            toggle <= 1'b0;
        end else if (flag_i) begin
            toggle <= ~toggle;
        end
    end

    // Pulses closer together than the chain length merge or vanish
    always_ff @(posedge dst_clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            sync <= '0;
        end else begin
            sync <= {sync[STAGES-2:0], toggle};
        end
    end

    // Edge of the synchronized toggle
    assign flag_o = sync[STAGES-1] ^ sync[STAGES-2];

endmodule

`default_nettype wire

/* design/edge_counter.sv */
`timescale 1ns/1ps
`default_nettype none

module edge_counter (
    input  logic           meas_clk_i,
    input  logic           rst_n_i,
    input  logic           gate_i,
    output fm_pkg::count_t latched_o,
    output logic           done_o
);
    import fm_pkg::*;

    count_t edge_cnt;  // Free running within a window

    always_ff @(posedge meas_clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            edge_cnt  <= '0;
            latched_o <= '0;
            done_o    <= 1'b0;
        end else begin
            done_o <= gate_i;  // Echo of the gate, goes back to ps_clk

            if (gate_i) begin
                // Count of the window just closed
                latched_o <= edge_cnt;
                // Gate edge itself belongs to the new window
                edge_cnt  <= count_t'(1);
            end else begin
                edge_cnt <= edge_cnt + 1'b1;
            end
        end
    end

    // latched_o then sits still for a whole window, so ps_clk reads it
    // directly once the echo has crossed over

endmodule

`default_nettype wire

/* design/result_capture.sv */
`timescale 1ns/1ps
`default_nettype none

module result_capture (
    input  logic                 ps_clk,
    input  logic                 rst_n_i,
    input  logic                 done_i,
    input  fm_pkg::count_t       latched_i,
    output fm_pkg::freq_result_t result_o
);
    logic primed;  // Set once the partial first window has passed
    logic load;

    // First done after reset carries a count that started mid-window
    assign load = done_i & primed;

    always_ff @(posedge ps_clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            primed         <= 1'b0;
            result_o.valid <= 1'b0;
            result_o.count <= '0;
        end else begin
            if (done_i) begin
                primed <= 1'b1;
            end

            // Strobe lines up with the new count
            result_o.valid <= load;

            if (load) begin
                result_o.count <= latched_i;
            end
        end
    end

endmodule

`default_nettype wire

/* design/freq_meter_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fm_config.svh"

module freq_meter_top (
    input  logic                                  ps_clk,
    input  logic                                  rst_n_i,
    input  logic [`FM_NUM_CH-1:0]                 meas_clk_i,
    output fm_pkg::freq_result_t [`FM_NUM_CH-1:0] result_o
);
    import fm_pkg::*;

    logic gate;  // One pulse per window, shared by all channels

    gate_timer u_gate_timer (
        .ps_clk  (ps_clk),
        .rst_n_i (rst_n_i),
        .gate_o  (gate)
    );

    for (genvar ch = 0; ch < `FM_NUM_CH; ch++) begin : g_ch
        logic   meas_gate;  // Gate in the measured domain
        logic   meas_done;  // Gate echo from the counter
        logic   ps_done;    // Echo back in ps_clk
        count_t latched;

        // ps_clk to measured clock
        flag_sync u_sync_in (
            .src_clk_i (ps_clk),
            .dst_clk_i (meas_clk_i[ch]),
            .rst_n_i   (rst_n_i),
            .flag_i    (gate),
            .flag_o    (meas_gate)
        );

        edge_counter u_edge_counter (
            .meas_clk_i (meas_clk_i[ch]),
            .rst_n_i    (rst_n_i),
            .gate_i     (meas_gate),
            .latched_o  (latched),
            .done_o     (meas_done)
        );

        // Measured clock back to ps_clk
        flag_sync u_sync_back (
            .src_clk_i (meas_clk_i[ch]),
            .dst_clk_i (ps_clk),
            .rst_n_i   (rst_n_i),
            .flag_i    (meas_done),
            .flag_o    (ps_done)
        );

        result_capture u_result_capture (
            .ps_clk    (ps_clk),
            .rst_n_i   (rst_n_i),
            .done_i    (ps_done),
            .latched_i (latched),
            .result_o  (result_o[ch])
        );
    end

endmodule

`default_nettype wire

/* bench/freq_meter_checker.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fm_config.svh"

module freq_meter_checker (
    input  logic                                  ps_clk,
    input  logic                                  rst_n_i,
    input  logic                                  gate_i,
    input  fm_pkg::freq_result_t [`FM_NUM_CH-1:0] result_i
);
    import fm_pkg::*;

    gate_cnt_t gates_seen;  // Saturates at 2
    int        assert_failures = 0;

    always_ff @(posedge ps_clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            gates_seen <= '0;
        end else if (gate_i && gates_seen < gate_cnt_t'(2)) begin
            gates_seen <= gates_seen + gate_cnt_t'(1);
        end
    end

    a_gate_single: assert property (@(posedge ps_clk) disable iff (!rst_n_i)
        gate_i |=> !gate_i)
        else begin
            assert_failures++;
            $error("Gate pulse longer than one cycle");
        end

    for (genvar ch = 0; ch < `FM_NUM_CH; ch++) begin : g_ch
        a_valid_single: assert property (@(posedge ps_clk) disable iff (!rst_n_i)
            result_i[ch].valid |=> !result_i[ch].valid)
            else begin
                assert_failures++;
                $error("Valid high two cycles in a row");
            end

        // Count only moves together with the strobe
        a_count_held: assert property (@(posedge ps_clk) disable iff (!rst_n_i)
            !result_i[ch].valid |-> $stable(result_i[ch].count))
            else begin
                assert_failures++;
                $error("Count changed without valid");
            end

        a_first_dropped: assert property (@(posedge ps_clk) disable iff (!rst_n_i)
            (gates_seen < gate_cnt_t'(2)) |-> !result_i[ch].valid)
            else begin
                assert_failures++;
                $error("Valid before the second gate");
            end
    end

endmodule

`default_nettype wire

/* bench/tb_clock_gen.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fm_config.svh"

module tb_clock_gen (
    input  logic [`FM_NUM_CH-1:0][15:0] meas_period_i,  // Periods in ns
    output logic                        ps_clk,
    output logic                        rst_n_o,
    output logic [`FM_NUM_CH-1:0]       meas_clk_o
);
    // ps_clk at 100 ns
    initial begin
        ps_clk = 1'b0;
        forever #50 ps_clk = ~ps_clk;
    end

    initial begin
        rst_n_o = 1'b0;
        repeat (2) @(posedge ps_clk);
        rst_n_o <= 1'b1;
    end

    for (genvar ch = 0; ch < `FM_NUM_CH; ch++) begin : g_meas
        logic clk;

        // New period takes effect at the next half cycle
        initial begin
            clk = 1'b0;
            forever begin
                #(real'(meas_period_i[ch]) / 2.0);
                clk = ~clk;
            end
        end

        assign meas_clk_o[ch] = clk;
    end

endmodule

`default_nettype wire

/* bench/tb_freq_meter.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fm_config.svh"

module tb_freq_meter;
    import fm_pkg::*;

    localparam int MAX_TESTS = 16;
    localparam int WINDOW_NS = `FM_GATE_CYCLES * 100;

    logic                          ps_clk;
    logic                          rst_n;
    logic [`FM_NUM_CH-1:0]         meas_clk;
    logic [`FM_NUM_CH-1:0][15:0]   meas_period = {`FM_NUM_CH{16'd100}};
    freq_result_t [`FM_NUM_CH-1:0] result;

    logic [15:0] trace_mem [4*MAX_TESTS];  // Four words per test
    int          strobes [`FM_NUM_CH] = '{default: 0};
    time         first_valid [`FM_NUM_CH] = '{default: 0};
    int          errors = 0;
    int          checks = 0;
    time         watchdog_ns = 0;

    tb_clock_gen u_clock_gen (
        .meas_period_i (meas_period),
        .ps_clk        (ps_clk),
        .rst_n_o       (rst_n),
        .meas_clk_o    (meas_clk)
    );

    freq_meter_top dut (
        .ps_clk     (ps_clk),
        .rst_n_i    (rst_n),
        .meas_clk_i (meas_clk),
        .result_o   (result)
    );

    bind freq_meter_top freq_meter_checker u_checker (
        .ps_clk   (ps_clk),
        .rst_n_i  (rst_n_i),
        .gate_i   (gate),
        .result_i (result_o)
    );

    // Strobe counter per channel
    always @(negedge ps_clk) begin
        for (int ch = 0; ch < `FM_NUM_CH; ch++) begin
            if (result[ch].valid) begin
                strobes[ch] = strobes[ch] + 1;
                if (first_valid[ch] == 0) begin
                    first_valid[ch] = $time;
                end
            end
        end
    end

    function automatic count_t expected_count(input int period_ns);
        return count_t'(WINDOW_NS / period_ns);
    endfunction

    task automatic check_count(input string name, input count_t expected,
                               input count_t actual, input int tolerance);
        longint diff;
        longint tol;
        diff = longint'(actual) - longint'(expected);
        tol  = longint'(tolerance);
        checks++;
        if (diff > tol || diff < -tol) begin
            $display("Error at %0t: %s expected %0d (+/- %0d) got %0d",
                     $time, name, expected, tolerance, actual);
            errors++;
        end
    endtask

    task automatic check_valid_total(input string name, input int expected, input int actual);
        checks++;
        if (actual != expected) begin
            $display("Error at %0t: %s expected %0d got %0d", $time, name, expected, actual);
            errors++;
        end
    endtask

    task automatic collect_channel(input int ch, input int windows, input bit discard,
                                   input count_t expected);
        int     total;
        int     seen;
        count_t announced;
        string  name;
        total = windows + int'(discard);
        seen  = 0;
        name  = $sformatf("result_o[%0d].count", ch);
        while (seen < total) begin
            @(negedge ps_clk);
            if (result[ch].valid) begin
                announced = result[ch].count;
                if (!discard || seen > 0) begin
                    check_count(name, expected, announced, 1);
                end
                seen++;
                if (seen < total) begin
                    repeat (`FM_GATE_CYCLES / 2) @(negedge ps_clk);  // Midway to next strobe
                    check_count(name, announced, result[ch].count, 0);
                end
            end
        end
    endtask

    initial begin
        wait (watchdog_ns != 0);
        #(watchdog_ns);
        $display("Run timed out waiting for a result strobe");
        $display("RESULT: FAIL");
        $finish;
    end

    initial begin
        int          num_tests;
        int          total_windows;
        int          windows;
        int          delay;
        int          errors_before;
        int          base [`FM_NUM_CH];
        bit          discard;
        count_t      expected [`FM_NUM_CH];
        time         first_window_end;

        void'($urandom(32'h9faa8101));
        for (int i = 0; i < 4 * MAX_TESTS; i++) begin
            trace_mem[i] = 16'hffff;  // End marker
        end
        $readmemh("bench/freq_trace.txt", trace_mem);
        num_tests     = 0;
        total_windows = 0;
        while (num_tests < MAX_TESTS && trace_mem[4 * num_tests] != 16'hffff) begin
            total_windows += int'(trace_mem[4 * num_tests + 3]) + 2;
            num_tests++;
        end
        watchdog_ns = time'(total_windows) * time'(2 * WINDOW_NS) + time'(20 * WINDOW_NS);
        if (num_tests == 0) begin
            $display("Trace file holds no tests");
            errors++;
        end

        first_window_end = 0;
        for (int t = 0; t < num_tests; t++) begin
            windows = int'(trace_mem[4 * t + 3]);
            for (int ch = 0; ch < `FM_NUM_CH; ch++) begin
                expected[ch] = expected_count(int'(trace_mem[4 * t + 1 + ch]));
            end
            errors_before = errors;
            if (t == 0) begin
                @(posedge ps_clk);  // Still in reset
                for (int ch = 0; ch < `FM_NUM_CH; ch++) begin
                    meas_period[ch] <= trace_mem[4 * t + 1 + ch];
                end
                wait (rst_n);
                first_window_end = $time + time'(WINDOW_NS);
                discard = 1'b0;
            end else begin
                delay = int'($urandom_range(3, 0));
                repeat (delay) @(posedge ps_clk);
                for (int ch = 0; ch < `FM_NUM_CH; ch++) begin
                    meas_period[ch] <= trace_mem[4 * t + 1 + ch];
                end
                discard = 1'b1;  // Window in flight straddles the change
            end

            for (int ch = 0; ch < `FM_NUM_CH; ch++) begin
                base[ch] = strobes[ch];
            end
            fork
                collect_channel(0, windows, discard, expected[0]);
                collect_channel(1, windows, discard, expected[1]);
            join
            @(posedge ps_clk);

            for (int ch = 0; ch < `FM_NUM_CH; ch++) begin
                check_valid_total($sformatf("result_o[%0d].valid strobes", ch),
                                  windows + int'(discard), strobes[ch] - base[ch]);
                if (t == 0 && first_valid[ch] <= first_window_end) begin
                    $display("Channel %0d strobed valid inside the first window after reset", ch);
                    errors++;
                end
            end
            $display("Test %0d: periods %0d and %0d ns, %0d windows, expected %0d and %0d, %s",
                     int'(trace_mem[4 * t]), int'(trace_mem[4 * t + 1]),
                     int'(trace_mem[4 * t + 2]), windows, expected[0], expected[1],
                     (errors == errors_before) ? "ok" : "failed");
        end

        if (dut.u_checker.assert_failures != 0) begin
            $display("Checker assertions failed %0d times", dut.u_checker.assert_failures);
            errors += dut.u_checker.assert_failures;
        end
        $display("Summary: %0d tests, %0d checks, %0d errors", num_tests, checks, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* build.f */
+incdir+design
design/fm_pkg.sv
design/gate_timer.sv
design/flag_sync.sv
design/edge_counter.sv
design/result_capture.sv
design/freq_meter_top.sv
bench/freq_meter_checker.sv
bench/tb_clock_gen.sv
bench/tb_freq_meter.sv

/* run_sim.sh */
#!/bin/sh
# Builds and runs the frequency meter testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_freq_meter -f build.f -o sim_freq_meter \
    && ./obj_dir/sim_freq_meter +verilator+error+limit+100 > sim.log 2>&1

cat sim.log 2>/dev/null

grep -q "^RESULT: PASS$" sim.log \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

/* bench/freq_trace.txt */
// Columns in hex: test id, channel 0 period ns, channel 1 period ns, windows to check
// Expected count per window is 6400 ns divided by the period
01 0014 0014 0004  // 20 ns on both, 320
02 000a 0032 0004  // 10 ns and 50 ns, 640 and 128
03 0032 000a 0003  // Swapped, 128 and 640
04 001e 0050 0004  // 30 ns and 80 ns, 213 and 80
05 000e 0040 0003  // 14 ns and 64 ns, 457 and 100
06 0014 0014 0003  // Back to 20 ns, 320
